// ==== logic/wb_pkg.sv ====
// ==============================
// wb_pkg
// shared widths and the physical
// register index for the writeback path
// ==============================

`default_nettype none

package wb_pkg;

	// data word
	localparam int xlen = 64;

	// architectural register file
	localparam int arch_regs = 32;
	localparam int arch_w = $clog2(arch_regs);

	// rename depth, rp copies of every register
	localparam int rb = 2;
	localparam int rp = 2 ** rb;

	// physical register space
	localparam int phy_w = arch_w + rb;
	localparam int phy_regs = arch_regs * rp;

	// alu, jal, bru, lsu, csr
	localparam int n_units = 5;

	typedef logic [xlen-1:0] xlen_t;

	// physical index, flat number is arch * rp + depth
	typedef union packed {
		logic [phy_w-1:0] flat;
		struct packed {
			logic [arch_w-1:0] arch;
			logic [rb-1:0] depth;
		} fields;
	} phy_idx_t;

endpackage

`default_nettype wire

// ==== logic/wb_merge.sv ====
// ==============================
// wb_merge
// folds the five unit writebacks into
// the next physical register state
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_merge (
	input wire [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_q,

	// alu
	input wire alu_wb_valid,
	input wire wb_pkg::phy_idx_t alu_wb_rd,
	input wire wb_pkg::xlen_t alu_wb_res,

	// jal
	input wire jal_wb_valid,
	input wire wb_pkg::phy_idx_t jal_wb_rd,
	input wire wb_pkg::xlen_t jal_wb_res,

	// bru
	input wire bru_wb_valid,
	input wire wb_pkg::phy_idx_t bru_wb_rd,
	input wire wb_pkg::xlen_t bru_wb_res,

	// lsu
	input wire lsu_wb_valid,
	input wire wb_pkg::phy_idx_t lsu_wb_rd,
	input wire wb_pkg::xlen_t lsu_wb_res,

	// csr
	input wire csr_wb_valid,
	input wire wb_pkg::phy_idx_t csr_wb_rd,
	input wire wb_pkg::xlen_t csr_wb_res,

	output logic [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_d,
	output logic [wb_pkg::phy_regs-1:0] wb_set
);

	// units gathered into arrays so every copy runs one loop
	logic [wb_pkg::n_units-1:0] unit_valid;
	wb_pkg::phy_idx_t unit_rd [wb_pkg::n_units];
	wb_pkg::xlen_t unit_res [wb_pkg::n_units];

	assign unit_valid = {csr_wb_valid, lsu_wb_valid, bru_wb_valid, jal_wb_valid, alu_wb_valid};

	always_comb begin
		unit_rd[0] = alu_wb_rd;
		unit_rd[1] = jal_wb_rd;
		unit_rd[2] = bru_wb_rd;
		unit_rd[3] = lsu_wb_rd;
		unit_rd[4] = csr_wb_rd;
		unit_res[0] = alu_wb_res;
		unit_res[1] = jal_wb_res;
		unit_res[2] = bru_wb_res;
		unit_res[3] = lsu_wb_res;
		unit_res[4] = csr_wb_res;
	end

	for (genvar sel = 0; sel < wb_pkg::phy_regs; sel++) begin : g_phy
		if (sel < wb_pkg::rp) begin : g_x0
			// x0 copies never take a result
			assign regs_d[sel*wb_pkg::xlen +: wb_pkg::xlen] = '0;
		end else begin : g_merge
			logic [wb_pkg::n_units-1:0] hit;
			wb_pkg::xlen_t merged;

			// units never share a destination, so OR is a plain select
			always_comb begin
				merged = '0;
				for (int u = 0; u < wb_pkg::n_units; u++) begin
					hit[u] = unit_valid[u] & (unit_rd[u].flat == sel);
					merged = merged | ({wb_pkg::xlen{hit[u]}} & unit_res[u]);
				end
			end

			// nobody wrote this copy, hold it
			assign regs_d[sel*wb_pkg::xlen +: wb_pkg::xlen] =
				(|hit) ? merged : regs_q[sel*wb_pkg::xlen +: wb_pkg::xlen];
		end
	end

	// one bit per destination named this cycle
	always_comb begin
		wb_set = '0;
		for (int u = 0; u < wb_pkg::n_units; u++) begin
			if (unit_valid[u]) begin
				wb_set[unit_rd[u].flat] = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/phy_regfile.sv ====
// ==============================
// phy_regfile
// physical register storage and the
// committed-value read mux
// ==============================

`timescale 1ns/1ps
`default_nettype none

module phy_regfile (
	input wire clk,
	input wire arst_n,
	input wire [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_d,
	input wire wb_pkg::phy_idx_t rd_phy,
	output logic [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_q,
	output wb_pkg::xlen_t rd_data
);

	// whole file loads every cycle, merge supplies the hold value
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs_q <= '0;
		end else begin
			regs_q <= regs_d;
			// x0 copies pinned to zero whatever arrives
			regs_q[0 +: wb_pkg::rp*wb_pkg::xlen] <= '0;
		end
	end

	// read by flat index
	// zero cycles from rd_phy
	assign rd_data = regs_q[rd_phy.flat*wb_pkg::xlen +: wb_pkg::xlen];

endmodule

`default_nettype wire

// ==== logic/wb_log.sv ====
// ==============================
// wb_log
// written flag per physical copy
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_log (
	input wire clk,
	input wire arst_n,
	input wire [wb_pkg::phy_regs-1:0] wb_set,
	input wire alloc_fire,
	input wire wb_pkg::phy_idx_t alloc_phy,
	output logic [wb_pkg::phy_regs-1:0] written
);

	// clear mask laid out arch major, depth minor
	// flattens to the same order as the flat index
	logic [wb_pkg::arch_regs-1:0][wb_pkg::rp-1:0] clr;

	// fresh copy has no result yet
	always_comb begin
		clr = '0;
		clr[alloc_phy.fields.arch][alloc_phy.fields.depth] = alloc_fire;
	end

	// set applied after clear, so a set wins on collision
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			written <= '0;
		end else begin
			written <= (written & ~clr) | wb_set;
		end
	end

endmodule

`default_nettype wire

// ==== logic/rename_ctrl.sv ====
// ==============================
// rename_ctrl
// rename and commit pointers per register,
// copy allocation and committed read index
// ==============================

`timescale 1ns/1ps
`default_nettype none

module rename_ctrl (
	input wire clk,
	input wire arst_n,

	// rename request
	input wire alloc_valid,
	input wire [wb_pkg::arch_w-1:0] alloc_arch,

	// retire request
	input wire commit_valid,
	input wire [wb_pkg::arch_w-1:0] commit_arch,

	// committed read
	input wire [wb_pkg::arch_w-1:0] rd_arch,

	output logic alloc_ok,
	output logic alloc_fire,
	output wb_pkg::phy_idx_t alloc_phy,
	output wb_pkg::phy_idx_t rd_phy
);

	// newest renamed copy
	logic [wb_pkg::arch_regs-1:0][wb_pkg::rb-1:0] ren_ptr_q;
	// committed copy
	logic [wb_pkg::arch_regs-1:0][wb_pkg::rb-1:0] cmt_ptr_q;
	// copies between the two pointers
	logic [wb_pkg::arch_regs-1:0][wb_pkg::rb-1:0] cnt_q;

	logic commit_fire;
	logic [wb_pkg::arch_regs-1:0] alloc_sel;
	logic [wb_pkg::arch_regs-1:0] commit_sel;

	// one copy always stays committed, so rp-1 in flight is full
	assign alloc_ok = cnt_q[alloc_arch] < (wb_pkg::rp - 1);
	assign alloc_fire = alloc_valid & alloc_ok;

	// nothing in flight means nothing to retire
	assign commit_fire = commit_valid & (cnt_q[commit_arch] != '0);

	always_comb begin
		alloc_sel = '0;
		alloc_sel[alloc_arch] = alloc_fire;
		commit_sel = '0;
		commit_sel[commit_arch] = commit_fire;
	end

	// copy after the rename pointer, wraps mod rp
	always_comb begin
		alloc_phy.fields.arch = alloc_arch;
		alloc_phy.fields.depth = ren_ptr_q[alloc_arch] + 1'b1;
	end

	always_comb begin
		rd_phy.fields.arch = rd_arch;
		rd_phy.fields.depth = cmt_ptr_q[rd_arch];
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ren_ptr_q <= '0;
			cmt_ptr_q <= '0;
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < wb_pkg::arch_regs; i++) begin
				if (alloc_sel[i]) begin
					ren_ptr_q[i] <= ren_ptr_q[i] + 1'b1;
				end
				if (commit_sel[i]) begin
					cmt_ptr_q[i] <= cmt_ptr_q[i] + 1'b1;
				end
				// alloc and commit together leave the count alone
				case ({alloc_sel[i], commit_sel[i]})
					2'b10: cnt_q[i] <= cnt_q[i] + 1'b1;
					2'b01: cnt_q[i] <= cnt_q[i] - 1'b1;
					default: cnt_q[i] <= cnt_q[i];
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/wb_core.sv ====
// ==============================
// wb_core
// register side of the core, rename,
// writeback merge, log and commit
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_core (
	input wire clk,
	input wire arst_n,

	// unit writebacks
	input wire alu_wb_valid,
	input wire [wb_pkg::phy_w-1:0] alu_wb_rd,
	input wire [wb_pkg::xlen-1:0] alu_wb_res,
	input wire jal_wb_valid,
	input wire [wb_pkg::phy_w-1:0] jal_wb_rd,
	input wire [wb_pkg::xlen-1:0] jal_wb_res,
	input wire bru_wb_valid,
	input wire [wb_pkg::phy_w-1:0] bru_wb_rd,
	input wire [wb_pkg::xlen-1:0] bru_wb_res,
	input wire lsu_wb_valid,
	input wire [wb_pkg::phy_w-1:0] lsu_wb_rd,
	input wire [wb_pkg::xlen-1:0] lsu_wb_res,
	input wire csr_wb_valid,
	input wire [wb_pkg::phy_w-1:0] csr_wb_rd,
	input wire [wb_pkg::xlen-1:0] csr_wb_res,

	// rename
	input wire alloc_valid,
	input wire [wb_pkg::arch_w-1:0] alloc_arch,
	output logic alloc_ok,
	output logic [wb_pkg::phy_w-1:0] alloc_phy,

	// retire
	input wire commit_valid,
	input wire [wb_pkg::arch_w-1:0] commit_arch,

	// committed read port
	input wire [wb_pkg::arch_w-1:0] rd_arch,
	output logic [wb_pkg::xlen-1:0] rd_data,

	output logic [wb_pkg::phy_regs-1:0] wb_written
);

	// unit destinations as physical indices
	wb_pkg::phy_idx_t alu_rd;
	wb_pkg::phy_idx_t jal_rd;
	wb_pkg::phy_idx_t bru_rd;
	wb_pkg::phy_idx_t lsu_rd;
	wb_pkg::phy_idx_t csr_rd;

	logic [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_q;
	logic [wb_pkg::phy_regs*wb_pkg::xlen-1:0] regs_d;
	logic [wb_pkg::phy_regs-1:0] wb_set;
	logic alloc_fire;
	wb_pkg::phy_idx_t alloc_idx;
	wb_pkg::phy_idx_t rd_phy;

	assign alu_rd = alu_wb_rd;
	assign jal_rd = jal_wb_rd;
	assign bru_rd = bru_wb_rd;
	assign lsu_rd = lsu_wb_rd;
	assign csr_rd = csr_wb_rd;

	assign alloc_phy = alloc_idx.flat;

	wb_merge u_merge (
		.regs_q(regs_q),
		.alu_wb_valid(alu_wb_valid), .alu_wb_rd(alu_rd), .alu_wb_res(alu_wb_res),
		.jal_wb_valid(jal_wb_valid), .jal_wb_rd(jal_rd), .jal_wb_res(jal_wb_res),
		.bru_wb_valid(bru_wb_valid), .bru_wb_rd(bru_rd), .bru_wb_res(bru_wb_res),
		.lsu_wb_valid(lsu_wb_valid), .lsu_wb_rd(lsu_rd), .lsu_wb_res(lsu_wb_res),
		.csr_wb_valid(csr_wb_valid), .csr_wb_rd(csr_rd), .csr_wb_res(csr_wb_res),
		.regs_d(regs_d),
		.wb_set(wb_set)
	);

	phy_regfile u_regfile (
		.clk(clk),
		.arst_n(arst_n),
		.regs_d(regs_d),
		.rd_phy(rd_phy),
		.regs_q(regs_q),
		.rd_data(rd_data)
	);

	wb_log u_log (
		.clk(clk),
		.arst_n(arst_n),
		.wb_set(wb_set),
		.alloc_fire(alloc_fire),
		.alloc_phy(alloc_idx),
		.written(wb_written)
	);

	rename_ctrl u_rename (
		.clk(clk),
		.arst_n(arst_n),
		.alloc_valid(alloc_valid),
		.alloc_arch(alloc_arch),
		.commit_valid(commit_valid),
		.commit_arch(commit_arch),
		.rd_arch(rd_arch),
		.alloc_ok(alloc_ok),
		.alloc_fire(alloc_fire),
		.alloc_phy(alloc_idx),
		.rd_phy(rd_phy)
	);

endmodule

`default_nettype wire

// ==== verification/wb_core_checker.sv ====
// ==============================
// wb_core_checker
// protocol assertions on the unit
// writebacks and the rename port
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_core_checker (
	input wire clk,
	input wire arst_n,
	input wire alu_wb_valid,
	input wire [wb_pkg::phy_w-1:0] alu_wb_rd,
	input wire jal_wb_valid,
	input wire [wb_pkg::phy_w-1:0] jal_wb_rd,
	input wire bru_wb_valid,
	input wire [wb_pkg::phy_w-1:0] bru_wb_rd,
	input wire lsu_wb_valid,
	input wire [wb_pkg::phy_w-1:0] lsu_wb_rd,
	input wire csr_wb_valid,
	input wire [wb_pkg::phy_w-1:0] csr_wb_rd,
	input wire alloc_valid,
	input wire alloc_ok
);

	// failures seen so far, read by the testbench summary
	int assert_errs = 0;

	logic [wb_pkg::n_units-1:0] valid;
	logic [wb_pkg::phy_w-1:0] rd [wb_pkg::n_units];

	assign valid = {csr_wb_valid, lsu_wb_valid, bru_wb_valid, jal_wb_valid, alu_wb_valid};
	assign rd[0] = alu_wb_rd;
	assign rd[1] = jal_wb_rd;
	assign rd[2] = bru_wb_rd;
	assign rd[3] = lsu_wb_rd;
	assign rd[4] = csr_wb_rd;

	// every unit pair, merge ORs so a shared copy would corrupt it
	for (genvar a = 0; a < wb_pkg::n_units; a++) begin : g_a
		for (genvar b = a + 1; b < wb_pkg::n_units; b++) begin : g_b
			a_unique_rd: assert property (@(posedge clk) disable iff (!arst_n)
				!(valid[a] && valid[b] && (rd[a] == rd[b])))
			else begin
				$error("units %0d and %0d wrote the same copy", a, b);
				assert_errs++;
			end
		end
	end

	// requester holds off while no copy is free
	a_alloc_ok: assert property (@(posedge clk) disable iff (!arst_n)
		alloc_valid |-> alloc_ok)
	else begin
		$error("alloc_valid raised while alloc_ok was low");
		assert_errs++;
	end

	// empty pointers out of reset leave room
	a_ok_after_reset: assert property (@(posedge clk) $rose(arst_n) |-> alloc_ok)
	else begin
		$error("alloc_ok low in the first cycle after reset");
		assert_errs++;
	end

endmodule

bind wb_core wb_core_checker u_checker (.*);

`default_nettype wire

// ==== verification/wb_core_tb.sv ====
// ==============================
// wb_core_tb
// trace driven testbench for the
// register writeback subsystem
// ==============================

`timescale 1ns/1ps
`default_nettype none

module wb_core_tb;

	localparam int period = 40;
	localparam int rst_cycles = 16;
	localparam int n_recs = 64;
	localparam int max_gap = 3;
	// reset, the zero sweep, then every record at its longest gap
	localparam int wd_cycles = rst_cycles + wb_pkg::arch_regs + n_recs * (max_gap + 1) + 8;
	// op, unit, arg, then 128 data bits
	localparam int rec_w = 144;

	logic clk = 1'b0;
	logic arst_n;
	logic [wb_pkg::n_units-1:0] wb_valid;
	logic [wb_pkg::phy_w-1:0] wb_rd [wb_pkg::n_units];
	logic [wb_pkg::xlen-1:0] wb_res [wb_pkg::n_units];
	logic alloc_valid;
	logic [wb_pkg::arch_w-1:0] alloc_arch;
	logic commit_valid;
	logic [wb_pkg::arch_w-1:0] commit_arch;
	logic [wb_pkg::arch_w-1:0] rd_arch;
	logic alloc_ok;
	logic [wb_pkg::phy_w-1:0] alloc_phy;
	logic [wb_pkg::xlen-1:0] rd_data;
	logic [wb_pkg::phy_regs-1:0] wb_written;

	logic [rec_w-1:0] trace_mem [n_recs];
	integer seed;
	int data_errs = 0;
	int phy_errs = 0;
	int bit_errs = 0;
	int log_errs = 0;
	int other_errs = 0;

	wb_core u_wb_core (
		.clk(clk),
		.arst_n(arst_n),
		.alu_wb_valid(wb_valid[0]), .alu_wb_rd(wb_rd[0]), .alu_wb_res(wb_res[0]),
		.jal_wb_valid(wb_valid[1]), .jal_wb_rd(wb_rd[1]), .jal_wb_res(wb_res[1]),
		.bru_wb_valid(wb_valid[2]), .bru_wb_rd(wb_rd[2]), .bru_wb_res(wb_res[2]),
		.lsu_wb_valid(wb_valid[3]), .lsu_wb_rd(wb_rd[3]), .lsu_wb_res(wb_res[3]),
		.csr_wb_valid(wb_valid[4]), .csr_wb_rd(wb_rd[4]), .csr_wb_res(wb_res[4]),
		.alloc_valid(alloc_valid), .alloc_arch(alloc_arch),
		.alloc_ok(alloc_ok), .alloc_phy(alloc_phy),
		.commit_valid(commit_valid), .commit_arch(commit_arch),
		.rd_arch(rd_arch), .rd_data(rd_data),
		.wb_written(wb_written)
	);

	always #(period / 2) clk = ~clk;

	task automatic check_data(input string name, input wb_pkg::xlen_t exp,
			input wb_pkg::xlen_t act);
		if (act !== exp) begin
			data_errs++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_phy(input string name, input wb_pkg::phy_idx_t exp,
			input wb_pkg::phy_idx_t act);
		if (act !== exp) begin
			phy_errs++;
			$display("FAIL %s expected %h actual %h", name, exp.flat, act.flat);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			bit_errs++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_log(input string name, input logic [wb_pkg::phy_regs-1:0] exp,
			input logic [wb_pkg::phy_regs-1:0] act);
		if (act !== exp) begin
			log_errs++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	// strobes low between records
	task automatic idle_inputs();
		wb_valid = '0;
		alloc_valid = 1'b0;
		commit_valid = 1'b0;
		for (int u = 0; u < wb_pkg::n_units; u++) begin
			wb_rd[u] = '0;
			wb_res[u] = '0;
		end
	endtask

	task automatic drive_wb(input logic [rec_w-1:0] rec);
		int u;
		u = rec[139:136];
		wb_valid[u] = 1'b1;
		wb_rd[u] = rec[134:128];
		wb_res[u] = rec[63:0];
	endtask

	initial begin
		int idx;
		int gap;
		logic [rec_w-1:0] rec;
		seed = 32'haf60c2ef;
		arst_n = 1'b0;
		rd_arch = '0;
		alloc_arch = '0;
		commit_arch = '0;
		idle_inputs();
		for (int i = 0; i < n_recs; i++) begin
			trace_mem[i] = '0;
		end
		$readmemh("verification/wb_trace.txt", trace_mem);
		repeat (rst_cycles) @(posedge clk);
		#1;
		arst_n = 1'b1;
		// out of reset every committed copy is zero and nothing is logged
		for (int a = 0; a < wb_pkg::arch_regs; a++) begin
			rd_arch = a;
			#(period - 2);
			check_data("rd_data", '0, rd_data);
			check_bit("alloc_ok", 1'b1, alloc_ok);
			check_log("wb_written", '0, wb_written);
			@(posedge clk);
			#1;
		end
		idx = 0;
		while (idx < n_recs && trace_mem[idx][143:140] != 4'h0) begin
			gap = {$random(seed)} % (max_gap + 1);
			repeat (gap) begin
				@(posedge clk);
				#1;
			end
			rec = trace_mem[idx];
			idx++;
			// op 2 chains into the closing op 3, all in one cycle
			while (rec[143:140] == 4'h2 && idx < n_recs) begin
				drive_wb(rec);
				rec = trace_mem[idx];
				idx++;
			end
			case (rec[143:140])
				4'h1: begin
					alloc_valid = 1'b1;
					alloc_arch = rec[132:128];
				end
				4'h3: drive_wb(rec);
				4'h4: begin
					commit_valid = 1'b1;
					commit_arch = rec[132:128];
				end
				4'h5: rd_arch = rec[132:128];
				4'h6: ;
				// probe looks at the rename port without a request
				4'h7: alloc_arch = rec[132:128];
				default: begin
					other_errs++;
					$display("trace record %0d has an unknown operation", idx - 1);
				end
			endcase
			#(period - 2);
			case (rec[143:140])
				4'h1, 4'h7: begin
					check_bit("alloc_ok", rec[8], alloc_ok);
					check_phy("alloc_phy", rec[6:0], alloc_phy);
				end
				4'h5: check_data("rd_data", rec[63:0], rd_data);
				4'h6: check_log("wb_written", rec[127:0], wb_written);
				default: ;
			endcase
			@(posedge clk);
			#1;
			idle_inputs();
		end
		if (idx == 0) begin
			other_errs++;
			$display("the trace file held no records");
		end
		$display("errors: data %0d phy %0d ok %0d log %0d assert %0d other %0d",
			data_errs, phy_errs, bit_errs, log_errs,
			u_wb_core.u_checker.assert_errs, other_errs);
		if (data_errs + phy_errs + bit_errs + log_errs + other_errs
				+ u_wb_core.u_checker.assert_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// run cannot outlast reset plus every record at its longest gap
	initial begin
		#(wd_cycles * period);
		$display("watchdog expired, the trace did not finish in %0d cycles", wd_cycles);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/wb_trace.txt ====
// columns: op(1) unit(1) arg(2) data(32); op 1 alloc 2 wb more 3 wb last 4 commit
// 5 read 6 log 7 probe; alloc and probe data is ok at bit 8 and phy at bits 6:0
600000000000000000000000000000000000
100100000000000000000000000000000105
100200000000000000000000000000000109
200500000000000000001111111111111111
310900000000000000002222222222222222
500100000000000000000000000000000000
600000000000000000000000000000000220
400100000000000000000000000000000000
500100000000000000001111111111111111
400200000000000000000000000000000000
500200000000000000002222222222222222
100100000000000000000000000000000106
320600000000000000003333333333333333
100100000000000000000000000000000107
10030000000000000000000000000000010D
230700000000000000004444444444444444
340D00000000000000005555555555555555
500100000000000000001111111111111111
6000000000000000000000000000000022E0
400100000000000000000000000000000000
500100000000000000003333333333333333
400100000000000000000000000000000000
500100000000000000004444444444444444
400300000000000000000000000000000000
500300000000000000005555555555555555
100100000000000000000000000000000104
100100000000000000000000000000000105
6000000000000000000000000000000022C0
100000000000000000000000000000000101
30010000000000000000FFFFFFFFFFFFFFFF
400000000000000000000000000000000000
500000000000000000000000000000000000
100400000000000000000000000000000111
100400000000000000000000000000000112
100400000000000000000000000000000113
700400000000000000000000000000000010
400400000000000000000000000000000000
100400000000000000000000000000000110
700400000000000000000000000000000011
6000000000000000000000000000000022C2

// ==== vlog.f ====
logic/wb_pkg.sv
logic/wb_merge.sv
logic/phy_regfile.sv
logic/wb_log.sv
logic/rename_ctrl.sv
logic/wb_core.sv
verification/wb_core_checker.sv
verification/wb_core_tb.sv
